// ==== hw/bp_cc_pkg.sv ====
package bp_cc_pkg;

  localparam int cc_x_dim = 2;
  localparam int cc_y_dim = 2;
  localparam int sp_depth = 16; // words per tile.

  // queued read, replayed as an op_resp flit.
  typedef struct packed
  {
    logic [bp_noc_pkg::x_cord_width-1:0] src_x;
    logic [bp_noc_pkg::y_cord_width-1:0] src_y;
    logic [bp_noc_pkg::addr_width-1:0]   addr;
    logic [bp_noc_pkg::data_width-1:0]   data;
  } resp_entry_t;

endpackage

// ==== hw/bp_core_complex.sv ====
`timescale 1ns/1ps

module bp_core_complex (
  input  logic                                          core_clk_i,
  input  logic                                          rst_n_i,

  input  logic [bp_cc_pkg::cc_x_dim-1:0]                link_v_i,
  input  bp_noc_pkg::flit_t [bp_cc_pkg::cc_x_dim-1:0]   link_data_i,
  output logic [bp_cc_pkg::cc_x_dim-1:0]                link_ready_and_o,

  output logic [bp_cc_pkg::cc_x_dim-1:0]                link_v_o,
  output bp_noc_pkg::flit_t [bp_cc_pkg::cc_x_dim-1:0]   link_data_o,
  input  logic [bp_cc_pkg::cc_x_dim-1:0]                link_ready_and_i
);

  // per tile, per edge direction; li feeds the tile, lo leaves it.
  logic [bp_cc_pkg::cc_y_dim-1:0][bp_cc_pkg::cc_x_dim-1:0]
        [bp_noc_pkg::dir_s:bp_noc_pkg::dir_w] v_li, v_lo, ready_li, ready_lo;
  bp_noc_pkg::flit_t [bp_cc_pkg::cc_y_dim-1:0][bp_cc_pkg::cc_x_dim-1:0]
        [bp_noc_pkg::dir_s:bp_noc_pkg::dir_w] data_li, data_lo;

  for (genvar j = 0; j < bp_cc_pkg::cc_y_dim; j++)
  begin : y
    for (genvar i = 0; i < bp_cc_pkg::cc_x_dim; i++)
    begin : x
      bp_tile_node u_tile_node (
        .core_clk_i   (core_clk_i),
        .rst_n_i      (rst_n_i),
        .my_x_i       (bp_noc_pkg::x_cord_width'(i)),
        .my_y_i       (bp_noc_pkg::y_cord_width'(j + 1)), // tiles start at row 1.
        .w_v_i        (v_li[j][i][bp_noc_pkg::dir_w]),
        .w_data_i     (data_li[j][i][bp_noc_pkg::dir_w]),
        .w_ready_and_o(ready_lo[j][i][bp_noc_pkg::dir_w]),
        .w_v_o        (v_lo[j][i][bp_noc_pkg::dir_w]),
        .w_data_o     (data_lo[j][i][bp_noc_pkg::dir_w]),
        .w_ready_and_i(ready_li[j][i][bp_noc_pkg::dir_w]),
        .e_v_i        (v_li[j][i][bp_noc_pkg::dir_e]),
        .e_data_i     (data_li[j][i][bp_noc_pkg::dir_e]),
        .e_ready_and_o(ready_lo[j][i][bp_noc_pkg::dir_e]),
        .e_v_o        (v_lo[j][i][bp_noc_pkg::dir_e]),
        .e_data_o     (data_lo[j][i][bp_noc_pkg::dir_e]),
        .e_ready_and_i(ready_li[j][i][bp_noc_pkg::dir_e]),
        .n_v_i        (v_li[j][i][bp_noc_pkg::dir_n]),
        .n_data_i     (data_li[j][i][bp_noc_pkg::dir_n]),
        .n_ready_and_o(ready_lo[j][i][bp_noc_pkg::dir_n]),
        .n_v_o        (v_lo[j][i][bp_noc_pkg::dir_n]),
        .n_data_o     (data_lo[j][i][bp_noc_pkg::dir_n]),
        .n_ready_and_i(ready_li[j][i][bp_noc_pkg::dir_n]),
        .s_v_i        (v_li[j][i][bp_noc_pkg::dir_s]),
        .s_data_i     (data_li[j][i][bp_noc_pkg::dir_s]),
        .s_ready_and_o(ready_lo[j][i][bp_noc_pkg::dir_s]),
        .s_v_o        (v_lo[j][i][bp_noc_pkg::dir_s]),
        .s_data_o     (data_lo[j][i][bp_noc_pkg::dir_s]),
        .s_ready_and_i(ready_li[j][i][bp_noc_pkg::dir_s])
      );

      if (i == 0)
      begin : w_edge
        assign v_li[j][i][bp_noc_pkg::dir_w]     = 1'b0;
        assign data_li[j][i][bp_noc_pkg::dir_w]  = '0;
        assign ready_li[j][i][bp_noc_pkg::dir_w] = 1'b1;
      end
      else
      begin : w_link
        assign v_li[j][i][bp_noc_pkg::dir_w]     = v_lo[j][i-1][bp_noc_pkg::dir_e];
        assign data_li[j][i][bp_noc_pkg::dir_w]  = data_lo[j][i-1][bp_noc_pkg::dir_e];
        assign ready_li[j][i][bp_noc_pkg::dir_w] = ready_lo[j][i-1][bp_noc_pkg::dir_e];
      end

      if (i == bp_cc_pkg::cc_x_dim - 1)
      begin : e_edge
        assign v_li[j][i][bp_noc_pkg::dir_e]     = 1'b0;
        assign data_li[j][i][bp_noc_pkg::dir_e]  = '0;
        assign ready_li[j][i][bp_noc_pkg::dir_e] = 1'b1;
      end
      else
      begin : e_link
        assign v_li[j][i][bp_noc_pkg::dir_e]     = v_lo[j][i+1][bp_noc_pkg::dir_w];
        assign data_li[j][i][bp_noc_pkg::dir_e]  = data_lo[j][i+1][bp_noc_pkg::dir_w];
        assign ready_li[j][i][bp_noc_pkg::dir_e] = ready_lo[j][i+1][bp_noc_pkg::dir_w];
      end

      if (j == 0)
      begin : n_ext
        assign v_li[j][i][bp_noc_pkg::dir_n]     = link_v_i[i];
        assign data_li[j][i][bp_noc_pkg::dir_n]  = link_data_i[i];
        assign ready_li[j][i][bp_noc_pkg::dir_n] = link_ready_and_i[i];
        assign link_v_o[i]         = v_lo[j][i][bp_noc_pkg::dir_n];
        assign link_data_o[i]      = data_lo[j][i][bp_noc_pkg::dir_n];
        assign link_ready_and_o[i] = ready_lo[j][i][bp_noc_pkg::dir_n];
      end
      else
      begin : n_link
        assign v_li[j][i][bp_noc_pkg::dir_n]     = v_lo[j-1][i][bp_noc_pkg::dir_s];
        assign data_li[j][i][bp_noc_pkg::dir_n]  = data_lo[j-1][i][bp_noc_pkg::dir_s];
        assign ready_li[j][i][bp_noc_pkg::dir_n] = ready_lo[j-1][i][bp_noc_pkg::dir_s];
      end

      if (j == bp_cc_pkg::cc_y_dim - 1)
      begin : s_edge
        assign v_li[j][i][bp_noc_pkg::dir_s]     = 1'b0;
        assign data_li[j][i][bp_noc_pkg::dir_s]  = '0;
        assign ready_li[j][i][bp_noc_pkg::dir_s] = 1'b1;
      end
      else
      begin : s_link
        assign v_li[j][i][bp_noc_pkg::dir_s]     = v_lo[j+1][i][bp_noc_pkg::dir_n];
        assign data_li[j][i][bp_noc_pkg::dir_s]  = data_lo[j+1][i][bp_noc_pkg::dir_n];
        assign ready_li[j][i][bp_noc_pkg::dir_s] = ready_lo[j+1][i][bp_noc_pkg::dir_n];
      end
    end
  end

endmodule

// ==== hw/bp_fifo.sv ====
`timescale 1ns/1ps

module bp_fifo #(
  parameter type payload_t = logic
) (
  input  logic     core_clk_i,
  input  logic     rst_n_i,

  input  logic     v_i,
  input  payload_t data_i,
  output logic     ready_and_o,

  output logic     v_o,
  output payload_t data_o,
  input  logic     yumi_i
);

  payload_t   mem_q [2];
  logic       wptr_q;
  logic       rptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  assign ready_and_o = count_q != 2'd2;
  assign v_o         = count_q != 2'd0;
  assign data_o      = mem_q[rptr_q];
  assign push        = v_i && ready_and_o;
  assign pop         = yumi_i;

  always_ff @(posedge core_clk_i)
  begin
    if (push)
    begin
      mem_q[wptr_q] <= data_i;
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      wptr_q  <= 1'b0;
      rptr_q  <= 1'b0;
      count_q <= 2'd0;
    end
    else
    begin
      if (push)
        wptr_q <= ~wptr_q;
      if (pop)
        rptr_q <= ~rptr_q;
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  // consumer may only take a head that exists.
  a_no_pop_empty: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    yumi_i |-> v_o);

  // a refused flit must wait, unchanged.
  a_hold_when_full: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    (v_i && !ready_and_o) |=> (v_i && $stable(data_i)));

endmodule

// ==== hw/bp_mesh_router.sv ====
`timescale 1ns/1ps

module bp_mesh_router (
  input  logic                                          core_clk_i,
  input  logic                                          rst_n_i,

  input  logic [bp_noc_pkg::x_cord_width-1:0]           my_x_i,
  input  logic [bp_noc_pkg::y_cord_width-1:0]           my_y_i,

  input  logic [bp_noc_pkg::num_dirs-1:0]               link_v_i,
  input  bp_noc_pkg::flit_t [bp_noc_pkg::num_dirs-1:0]  link_data_i,
  output logic [bp_noc_pkg::num_dirs-1:0]               link_ready_and_o,

  output logic [bp_noc_pkg::num_dirs-1:0]               link_v_o,
  output bp_noc_pkg::flit_t [bp_noc_pkg::num_dirs-1:0]  link_data_o,
  input  logic [bp_noc_pkg::num_dirs-1:0]               link_ready_and_i
);

  logic [bp_noc_pkg::num_dirs-1:0]                             head_v;
  logic [bp_noc_pkg::num_dirs-1:0]                             head_yumi;
  bp_noc_pkg::flit_t [bp_noc_pkg::num_dirs-1:0]                head_data;
  logic [bp_noc_pkg::num_dirs-1:0][bp_noc_pkg::dir_width-1:0]  head_dir;
  logic [bp_noc_pkg::num_dirs-1:0][bp_noc_pkg::dir_width-1:0]  grant;
  logic [bp_noc_pkg::num_dirs-1:0][bp_noc_pkg::dir_width-1:0]  ptr_q;

  // dimension ordered, x first.
  function automatic logic [bp_noc_pkg::dir_width-1:0] route(
    input bp_noc_pkg::flit_t                    flit,
    input logic [bp_noc_pkg::x_cord_width-1:0]  x,
    input logic [bp_noc_pkg::y_cord_width-1:0]  y
  );
    if (flit.dest_x > x)
      return bp_noc_pkg::dir_e;
    if (flit.dest_x < x)
      return bp_noc_pkg::dir_w;
    if (flit.dest_y < y)
      return bp_noc_pkg::dir_n;
    if (flit.dest_y > y)
      return bp_noc_pkg::dir_s;
    return bp_noc_pkg::dir_p;
  endfunction

  function automatic logic [bp_noc_pkg::dir_width-1:0] next_dir(
    input logic [bp_noc_pkg::dir_width-1:0] d
  );
    if (int'(d) == bp_noc_pkg::num_dirs - 1)
      return '0;
    return d + 1'b1;
  endfunction

  for (genvar k = 0; k < bp_noc_pkg::num_dirs; k++)
  begin : in
    bp_fifo #(
      .payload_t(bp_noc_pkg::flit_t)
    ) u_fifo (
      .core_clk_i (core_clk_i),
      .rst_n_i    (rst_n_i),
      .v_i        (link_v_i[k]),
      .data_i     (link_data_i[k]),
      .ready_and_o(link_ready_and_o[k]),
      .v_o        (head_v[k]),
      .data_o     (head_data[k]),
      .yumi_i     (head_yumi[k])
    );

    assign head_dir[k] = route(head_data[k], my_x_i, my_y_i);
  end

  // round robin from ptr_q, lowest offset wins.
  always_comb
  begin
    int idx;
    for (int d = 0; d < bp_noc_pkg::num_dirs; d++)
    begin
      link_v_o[d] = 1'b0;
      grant[d]    = ptr_q[d];
      for (int o = bp_noc_pkg::num_dirs - 1; o >= 0; o--)
      begin
        idx = (int'(ptr_q[d]) + o) % bp_noc_pkg::num_dirs;
        if (head_v[idx] && int'(head_dir[idx]) == d)
        begin
          link_v_o[d] = 1'b1;
          grant[d]    = bp_noc_pkg::dir_width'(idx);
        end
      end
      link_data_o[d] = head_data[grant[d]];
    end
  end

  always_comb
  begin
    head_yumi = '0;
    for (int d = 0; d < bp_noc_pkg::num_dirs; d++)
    begin
      if (link_v_o[d] && link_ready_and_i[d])
        head_yumi[grant[d]] = 1'b1;
    end
  end

  // a stalled output parks its pointer on the winner, so data holds.
  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      ptr_q <= '0;
    end
    else
    begin
      for (int d = 0; d < bp_noc_pkg::num_dirs; d++)
      begin
        if (link_v_o[d])
          ptr_q[d] <= link_ready_and_i[d] ? next_dir(grant[d]) : grant[d];
      end
    end
  end

  // edges of the grid are tied off in the top level.
  a_no_south_edge: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    link_v_o[bp_noc_pkg::dir_s] |-> int'(my_y_i) != bp_cc_pkg::cc_y_dim);

  a_no_west_edge: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    link_v_o[bp_noc_pkg::dir_w] |-> int'(my_x_i) != 0);

  a_no_east_edge: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    link_v_o[bp_noc_pkg::dir_e] |-> int'(my_x_i) != bp_cc_pkg::cc_x_dim - 1);

endmodule

// ==== hw/bp_noc_pkg.sv ====
package bp_noc_pkg;

  localparam int x_cord_width = 1;
  localparam int y_cord_width = 2; // row 0 is the north edge.
  localparam int addr_width   = 4;
  localparam int data_width   = 16;

  typedef enum logic [1:0]
  {
    op_write = 2'd0,
    op_read  = 2'd1,
    op_resp  = 2'd2
  } op_e;

  typedef struct packed
  {
    logic [x_cord_width-1:0] dest_x;
    logic [y_cord_width-1:0] dest_y;
    logic [x_cord_width-1:0] src_x;
    logic [y_cord_width-1:0] src_y;
    op_e                     op;
    logic [addr_width-1:0]   addr;
    logic [data_width-1:0]   data;
  } flit_t;

  localparam int dir_width = 3;
  localparam int num_dirs  = 5;

  localparam logic [dir_width-1:0] dir_p = 3'd0; // local endpoint.
  localparam logic [dir_width-1:0] dir_w = 3'd1;
  localparam logic [dir_width-1:0] dir_e = 3'd2;
  localparam logic [dir_width-1:0] dir_n = 3'd3;
  localparam logic [dir_width-1:0] dir_s = 3'd4;

endpackage

// ==== hw/bp_tile_node.sv ====
`timescale 1ns/1ps

module bp_tile_node (
  input  logic                                core_clk_i,
  input  logic                                rst_n_i,

  input  logic [bp_noc_pkg::x_cord_width-1:0] my_x_i,
  input  logic [bp_noc_pkg::y_cord_width-1:0] my_y_i,

  input  logic                                w_v_i,
  input  bp_noc_pkg::flit_t                   w_data_i,
  output logic                                w_ready_and_o,
  output logic                                w_v_o,
  output bp_noc_pkg::flit_t                   w_data_o,
  input  logic                                w_ready_and_i,

  input  logic                                e_v_i,
  input  bp_noc_pkg::flit_t                   e_data_i,
  output logic                                e_ready_and_o,
  output logic                                e_v_o,
  output bp_noc_pkg::flit_t                   e_data_o,
  input  logic                                e_ready_and_i,

  input  logic                                n_v_i,
  input  bp_noc_pkg::flit_t                   n_data_i,
  output logic                                n_ready_and_o,
  output logic                                n_v_o,
  output bp_noc_pkg::flit_t                   n_data_o,
  input  logic                                n_ready_and_i,

  input  logic                                s_v_i,
  input  bp_noc_pkg::flit_t                   s_data_i,
  output logic                                s_ready_and_o,
  output logic                                s_v_o,
  output bp_noc_pkg::flit_t                   s_data_o,
  input  logic                                s_ready_and_i
);

  logic [bp_noc_pkg::num_dirs-1:0]               rtr_v_li;
  logic [bp_noc_pkg::num_dirs-1:0]               rtr_ready_lo;
  logic [bp_noc_pkg::num_dirs-1:0]               rtr_v_lo;
  logic [bp_noc_pkg::num_dirs-1:0]               rtr_ready_li;
  bp_noc_pkg::flit_t [bp_noc_pkg::num_dirs-1:0]  rtr_data_li;
  bp_noc_pkg::flit_t [bp_noc_pkg::num_dirs-1:0]  rtr_data_lo;
  logic                                          sp_v_lo;
  logic                                          sp_ready_lo;
  bp_noc_pkg::flit_t                             sp_data_lo;

  // packed order is s, n, e, w, p.
  assign rtr_v_li     = {s_v_i, n_v_i, e_v_i, w_v_i, sp_v_lo};
  assign rtr_data_li  = {s_data_i, n_data_i, e_data_i, w_data_i, sp_data_lo};
  assign rtr_ready_li = {s_ready_and_i, n_ready_and_i, e_ready_and_i, w_ready_and_i,
                         sp_ready_lo};

  assign {s_v_o, n_v_o, e_v_o, w_v_o}                 = rtr_v_lo[bp_noc_pkg::dir_s:1];
  assign {s_data_o, n_data_o, e_data_o, w_data_o}     = rtr_data_lo[bp_noc_pkg::dir_s:1];
  assign {s_ready_and_o, n_ready_and_o, e_ready_and_o, w_ready_and_o}
    = rtr_ready_lo[bp_noc_pkg::dir_s:1];

  bp_mesh_router u_router (
    .core_clk_i      (core_clk_i),
    .rst_n_i         (rst_n_i),
    .my_x_i          (my_x_i),
    .my_y_i          (my_y_i),
    .link_v_i        (rtr_v_li),
    .link_data_i     (rtr_data_li),
    .link_ready_and_o(rtr_ready_lo),
    .link_v_o        (rtr_v_lo),
    .link_data_o     (rtr_data_lo),
    .link_ready_and_i(rtr_ready_li)
  );

  bp_tile_scratchpad u_scratchpad (
    .core_clk_i (core_clk_i),
    .rst_n_i    (rst_n_i),
    .my_x_i     (my_x_i),
    .my_y_i     (my_y_i),
    .v_i        (rtr_v_lo[bp_noc_pkg::dir_p]),
    .data_i     (rtr_data_lo[bp_noc_pkg::dir_p]),
    .ready_and_o(sp_ready_lo),
    .v_o        (sp_v_lo),
    .data_o     (sp_data_lo),
    .ready_and_i(rtr_ready_lo[bp_noc_pkg::dir_p])
  );

endmodule

// ==== hw/bp_tile_scratchpad.sv ====
`timescale 1ns/1ps

module bp_tile_scratchpad (
  input  logic                                core_clk_i,
  input  logic                                rst_n_i,

  input  logic [bp_noc_pkg::x_cord_width-1:0] my_x_i,
  input  logic [bp_noc_pkg::y_cord_width-1:0] my_y_i,

  input  logic                                v_i,
  input  bp_noc_pkg::flit_t                   data_i,
  output logic                                ready_and_o,

  output logic                                v_o,
  output bp_noc_pkg::flit_t                   data_o,
  input  logic                                ready_and_i
);

  logic [bp_noc_pkg::data_width-1:0] mem_q [bp_cc_pkg::sp_depth];
  logic                              is_read;
  logic                              resp_ready;
  bp_cc_pkg::resp_entry_t            resp_li;
  bp_cc_pkg::resp_entry_t            resp_lo;

  // writes never stall.
  assign is_read     = data_i.op == bp_noc_pkg::op_read;
  assign ready_and_o = !is_read || resp_ready;

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < bp_cc_pkg::sp_depth; i++)
        mem_q[i] <= '0;
    end
    else if (v_i && ready_and_o && data_i.op == bp_noc_pkg::op_write)
    begin
      mem_q[data_i.addr] <= data_i.data;
    end
  end

  always_comb
  begin
    resp_li.src_x = data_i.src_x;
    resp_li.src_y = data_i.src_y;
    resp_li.addr  = data_i.addr;
    resp_li.data  = mem_q[data_i.addr];
  end

  bp_fifo #(
    .payload_t(bp_cc_pkg::resp_entry_t)
  ) u_resp_fifo (
    .core_clk_i (core_clk_i),
    .rst_n_i    (rst_n_i),
    .v_i        (v_i && is_read),
    .data_i     (resp_li),
    .ready_and_o(resp_ready),
    .v_o        (v_o),
    .data_o     (resp_lo),
    .yumi_i     (v_o && ready_and_i)
  );

  always_comb
  begin
    data_o.dest_x = resp_lo.src_x; // back to the requester.
    data_o.dest_y = resp_lo.src_y;
    data_o.src_x  = my_x_i;
    data_o.src_y  = my_y_i;
    data_o.op     = bp_noc_pkg::op_resp;
    data_o.addr   = resp_lo.addr;
    data_o.data   = resp_lo.data;
  end

  // the router only delivers requests addressed here.
  a_local_request: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    (v_i && ready_and_o) |-> (data_i.dest_x == my_x_i && data_i.dest_y == my_y_i
                              && data_i.op != bp_noc_pkg::op_resp));

endmodule

// ==== list.f ====
hw/bp_noc_pkg.sv
hw/bp_cc_pkg.sv
hw/bp_fifo.sv
hw/bp_mesh_router.sv
hw/bp_tile_scratchpad.sv
hw/bp_tile_node.sv
hw/bp_core_complex.sv
verif/tb_core_complex.sv

// ==== verif/tb_core_complex.sv ====
`timescale 1ns/1ps

module tb_core_complex;

  localparam int cols        = bp_cc_pkg::cc_x_dim;
  localparam int tiles       = bp_cc_pkg::cc_x_dim * bp_cc_pkg::cc_y_dim;
  localparam int n_untouched = cols * tiles * 2;
  localparam int n_local     = cols * 16;
  localparam int n_cross     = cols * 16;
  localparam int n_stall     = cols * 30;
  localparam int n_mix       = cols * 80;
  localparam int total_ops   = n_untouched + n_local + n_cross + n_stall + n_mix;

  logic                         core_clk_i;
  logic                         rst_n_i;
  logic [cols-1:0]              link_v_i;
  bp_noc_pkg::flit_t [cols-1:0] link_data_i;
  logic [cols-1:0]              link_ready_and_o;
  logic [cols-1:0]              link_v_o;
  bp_noc_pkg::flit_t [cols-1:0] link_data_o;
  logic [cols-1:0]              link_ready_and_i;

  logic [15:0]                       lfsr_q;
  logic                              bp_en;
  int                                errors;
  int                                checks;
  logic [bp_noc_pkg::data_width-1:0] model_mem [tiles][bp_cc_pkg::sp_depth];
  bp_noc_pkg::flit_t                 op_q [cols][$];
  int                                idle_q [cols][$];
  bp_noc_pkg::flit_t                 exp_q [cols][tiles][$]; // per issuing column and tile.
  logic [cols-1:0]                   stall_q;
  bp_noc_pkg::flit_t                 held_q [cols];

  bp_core_complex u_bp_core_complex (
    .core_clk_i      (core_clk_i),
    .rst_n_i         (rst_n_i),
    .link_v_i        (link_v_i),
    .link_data_i     (link_data_i),
    .link_ready_and_o(link_ready_and_o),
    .link_v_o        (link_v_o),
    .link_data_o     (link_data_o),
    .link_ready_and_i(link_ready_and_i)
  );

  always #2 core_clk_i = ~core_clk_i;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_step(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // top address bit selects the issuing column.
  function automatic logic [bp_noc_pkg::addr_width-1:0] pick_addr(input int c);
    logic [31:0] r;
    r = rand_bits(bp_noc_pkg::addr_width - 1);
    return {c[0], r[bp_noc_pkg::addr_width-2:0]};
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int c = 0; c < cols; c++)
      for (int t = 0; t < tiles; t++)
        n += exp_q[c][t].size();
    return n;
  endfunction

  task automatic queue_op(input int c, input int x, input int y, input bit wr,
                          input logic [bp_noc_pkg::addr_width-1:0] addr,
                          input logic [bp_noc_pkg::data_width-1:0] data, input int idle);
    bp_noc_pkg::flit_t req;
    bp_noc_pkg::flit_t resp;
    int                t;
    t = (y - 1) * bp_cc_pkg::cc_x_dim + x;
    req.dest_x = bp_noc_pkg::x_cord_width'(x);
    req.dest_y = bp_noc_pkg::y_cord_width'(y);
    req.src_x  = bp_noc_pkg::x_cord_width'(c);
    req.src_y  = '0; // north edge.
    req.op     = wr ? bp_noc_pkg::op_write : bp_noc_pkg::op_read;
    req.addr   = addr;
    req.data   = wr ? data : '0;
    op_q[c].push_back(req);
    idle_q[c].push_back(idle);
    if (wr)
    begin
      model_mem[t][addr] = data;
    end
    else
    begin
      resp.dest_x = bp_noc_pkg::x_cord_width'(c);
      resp.dest_y = '0;
      resp.src_x  = bp_noc_pkg::x_cord_width'(x);
      resp.src_y  = bp_noc_pkg::y_cord_width'(y);
      resp.op     = bp_noc_pkg::op_resp;
      resp.addr   = addr;
      resp.data   = model_mem[t][addr];
      exp_q[c][t].push_back(resp);
    end
  endtask

  task automatic queue_write_read(input int c, input int x);
    logic [bp_noc_pkg::addr_width-1:0] addrs [8];
    logic [31:0]                       d;
    for (int k = 0; k < 8; k++)
    begin
      addrs[k] = pick_addr(c);
      d = rand_bits(bp_noc_pkg::data_width);
      queue_op(c, x, 1 + k / 4, 1'b1, addrs[k], d[15:0], 0);
    end
    for (int k = 0; k < 8; k++)
      queue_op(c, x, 1 + k / 4, 1'b0, addrs[k], '0, 0);
  endtask

  task automatic queue_random(input int c, input int n, input int idle_bits);
    logic [31:0]                       r;
    logic [31:0]                       d;
    logic [31:0]                       idle;
    logic [bp_noc_pkg::addr_width-1:0] addr;
    for (int k = 0; k < n; k++)
    begin
      r    = rand_bits(3);
      addr = pick_addr(c);
      d    = rand_bits(bp_noc_pkg::data_width);
      idle = rand_bits(idle_bits);
      queue_op(c, int'(r[0]), 1 + int'(r[1]), r[2], addr, d[15:0], int'(idle));
    end
  endtask

  task automatic drive_column(input int c);
    bp_noc_pkg::flit_t f;
    int                idle;
    @(posedge core_clk_i);
    while (op_q[c].size() > 0)
    begin
      f    = op_q[c].pop_front();
      idle = idle_q[c].pop_front();
      if (idle > 0)
      begin
        link_v_i[c] <= 1'b0;
        repeat (idle) @(posedge core_clk_i);
      end
      link_v_i[c]    <= 1'b1;
      link_data_i[c] <= f;
      @(negedge core_clk_i);
      while (!link_ready_and_o[c])
        @(negedge core_clk_i);
      @(posedge core_clk_i); // transfer happens on this edge.
    end
    link_v_i[c] <= 1'b0;
  endtask

  task automatic run_test(input string name);
    int base;
    int n;
    base = errors;
    n    = op_q[0].size() + op_q[1].size();
    fork
      drive_column(0);
      drive_column(1);
    join
    while (pending() > 0)
      @(posedge core_clk_i);
    @(negedge core_clk_i); // next stimulus is drawn away from the ready process.
    bp_en = 1'b0;
    $display("test %s: %0d ops, %0d errors", name, n, errors - base);
  endtask

  task automatic check_response(input int c, input bp_noc_pkg::flit_t got);
    bp_noc_pkg::flit_t exp;
    int                t;
    checks++;
    if (got.src_y < 1 || got.src_y > bp_cc_pkg::cc_y_dim)
    begin
      errors++;
      $display("response on column %0d names no tile, src_y is %0d", c, got.src_y);
    end
    else
    begin
      t = (int'(got.src_y) - 1) * bp_cc_pkg::cc_x_dim + int'(got.src_x);
      if (exp_q[c][t].size() == 0)
      begin
        errors++;
        $display("unexpected response on column %0d from tile %0d", c, t);
      end
      else
      begin
        exp = exp_q[c][t].pop_front();
        if (got !== exp)
        begin
          errors++;
          $display("MISMATCH link_data_o[%0d] exp %h got %h", c, exp, got);
        end
      end
    end
  endtask

  // random ready_and toward the DUT.
  always @(posedge core_clk_i)
  begin
    for (int c = 0; c < cols; c++)
    begin
      if (bp_en)
        link_ready_and_i[c] <= rand_bits(2) != 0;
      else
        link_ready_and_i[c] <= 1'b1;
    end
  end

  always @(negedge core_clk_i)
  begin
    if (rst_n_i)
    begin
      for (int c = 0; c < cols; c++)
      begin
        if (stall_q[c] && !link_v_o[c])
        begin
          errors++;
          $display("link_v_o[%0d] dropped while the link was stalled", c);
        end
        else if (stall_q[c] && link_data_o[c] !== held_q[c])
        begin
          errors++;
          $display("MISMATCH link_data_o[%0d] exp %h got %h", c, held_q[c], link_data_o[c]);
        end
        if (link_v_o[c] && link_ready_and_i[c])
          check_response(c, link_data_o[c]);
        stall_q[c] = link_v_o[c] && !link_ready_and_i[c];
        held_q[c]  = link_data_o[c];
      end
    end
  end

  initial
  begin
    repeat (total_ops * 40 + 200) @(posedge core_clk_i);
    $display("timeout: read responses still missing, %0d outstanding", pending());
    $display("Regression failed");
    $finish;
  end

  initial
  begin
    int base;
    core_clk_i       = 1'b0;
    rst_n_i          = 1'b0;
    link_v_i         = '0;
    link_data_i      = '0;
    link_ready_and_i = '1;
    lfsr_q           = 16'd13961;
    bp_en            = 1'b0;
    errors           = 0;
    checks           = 0;
    stall_q          = '0;
    for (int t = 0; t < tiles; t++)
      for (int a = 0; a < bp_cc_pkg::sp_depth; a++)
        model_mem[t][a] = '0;
    repeat (5) @(posedge core_clk_i);
    rst_n_i <= 1'b1;

    base = errors;
    repeat (10)
    begin
      @(negedge core_clk_i);
      checks++;
      if (link_v_o !== '0)
      begin
        errors++;
        $display("MISMATCH link_v_o exp %h got %h", 2'h0, link_v_o);
      end
      if (link_ready_and_o !== '1)
      begin
        errors++;
        $display("MISMATCH link_ready_and_o exp %h got %h", 2'h3, link_ready_and_o);
      end
    end
    $display("test reset: %0d errors", errors - base);

    for (int c = 0; c < cols; c++)
      for (int t = 0; t < tiles; t++)
        for (int k = 0; k < 2; k++)
          queue_op(c, t % bp_cc_pkg::cc_x_dim, 1 + t / bp_cc_pkg::cc_x_dim, 1'b0,
                   pick_addr(c), '0, 0);
    run_test("untouched_read");

    for (int c = 0; c < cols; c++)
      queue_write_read(c, c);
    run_test("write_read");

    for (int c = 0; c < cols; c++)
      queue_write_read(c, cols - 1 - c); // the other column's tiles.
    run_test("cross_column");

    for (int c = 0; c < cols; c++)
      queue_random(c, n_stall / cols, 1);
    bp_en = 1'b1;
    run_test("back_pressure");

    for (int c = 0; c < cols; c++)
      queue_random(c, n_mix / cols, 2);
    run_test("random_mix");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule
